// File: verilog/tag_dir_settings.svh
// ****************************************
// tag directory settings
// geometry of the set-associative tag store
// ****************************************

`ifndef TAG_DIR_SETTINGS_SVH
`define TAG_DIR_SETTINGS_SVH

// number of sets, power of two
`define TD_SETS 4

// ways per set, power of two
`define TD_WAYS 4

// width of a stored tag in bits
`define TD_TAG_W 8

`endif

// File: verilog/tag_dir_pkg.sv
// ****************************************
// tag directory types
// vector types shared by the directory blocks
// ****************************************

`include "tag_dir_settings.svh"

package tag_dir_pkg;

    // one stored tag
    typedef logic [`TD_TAG_W-1:0] tag_t;

    // index of a set
    typedef logic [$clog2(`TD_SETS)-1:0] set_idx_t;

    // index of a way inside a set
    typedef logic [$clog2(`TD_WAYS)-1:0] way_idx_t;

    // one bit per way
    typedef logic [`TD_WAYS-1:0] way_vec_t;

    // request address, set index in the low bits, tag above
    typedef logic [`TD_TAG_W+$clog2(`TD_SETS)-1:0] addr_t;

endpackage

// File: verilog/set_if.sv
// ****************************************
// set bus
// joins decoder, one set and the merger
// ****************************************

`timescale 1ns/1ps

interface set_if;
    import tag_dir_pkg::*;

    // request side, driven by the decoder
    logic     req;
    tag_t     tag;
    logic     flush;

    // result side, combinational from the set
    // only meaningful while req is high
    logic     hit;
    way_idx_t way;
    logic     evict_valid;
    tag_t     evict_tag;

    modport decode (
        output req, tag, flush
    );

    modport set (
        input  req, tag, flush,
        output hit, way, evict_valid, evict_tag
    );

    modport merge (
        input hit, way, evict_valid, evict_tag
    );

endinterface

// File: verilog/plru_tree.sv
// ****************************************
// pseudo-LRU tree
// tracks use order and names a one-hot victim
// ****************************************

`timescale 1ns/1ps

`include "tag_dir_settings.svh"

module plru_tree #(
    parameter int unsigned ENTRIES = `TD_WAYS
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  clear,
    input  tag_dir_pkg::way_vec_t used,
    output tag_dir_pkg::way_vec_t plru
);

    localparam int unsigned LogEntries = $clog2(ENTRIES);

    // heap layout: node 0 is the root, children of k are 2k+1 and 2k+2
    // 0 points to the lower half, 1 to the upper half
    logic [ENTRIES-2:0] tree_q;
    logic [ENTRIES-2:0] tree_d;

    // node that entry e passes through at level lvl
    function automatic int unsigned node_idx(int unsigned e, int unsigned lvl);
        return ((1 << lvl) - 1) + (e >> (LogEntries - lvl));
    endfunction

    // branch taken by entry e below level lvl, msb first
    function automatic logic path_bit(int unsigned e, int unsigned lvl);
        return ((e >> (LogEntries - lvl - 1)) & 1) != 0;
    endfunction

    // entry e is the victim when every node on its path points at it
    function automatic logic is_victim(logic [ENTRIES-2:0] t, int unsigned e);
        logic match;
        match = 1'b1;
        for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
            match &= (t[node_idx(e, lvl)] == path_bit(e, lvl));
        end
        return match;
    endfunction

    always_comb begin : tree_update
        tree_d = tree_q;
        // used is one-hot, turn its path away from it
        for (int unsigned e = 0; e < ENTRIES; e++) begin
            if (used[e]) begin
                for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                    tree_d[node_idx(e, lvl)] = ~path_bit(e, lvl);
                end
            end
        end
        // clear wins over any use
        if (clear) begin
            tree_d = '0;
        end
    end

    // victim comes from the registered tree only
    always_comb begin : victim_decode
        plru = '0;
        for (int unsigned e = 0; e < ENTRIES; e++) begin
            plru[e] = is_victim(tree_q, e);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    // entry count must be a power of two that fits the way mask
    if (ENTRIES < 2 || ENTRIES != (1 << LogEntries) ||
        ENTRIES > $bits(tag_dir_pkg::way_vec_t)) begin : g_bad_entries
        $error("plru_tree: ENTRIES must be a power of two between 2 and the way count");
    end

endmodule

// File: verilog/req_decode.sv
// ****************************************
// request decoder
// splits the address and strobes one set
// ****************************************

`timescale 1ns/1ps

`include "tag_dir_settings.svh"

module req_decode (
    input  logic               req_i,
    input  tag_dir_pkg::addr_t addr_i,
    input  logic               flush_i,
    set_if.decode              sets [`TD_SETS]
);
    import tag_dir_pkg::*;

    set_idx_t set_idx;
    tag_t     tag;
    logic     accept;

    // set index sits in the low address bits
    assign set_idx = addr_i[$bits(set_idx_t)-1:0];

    // tag takes the rest
    assign tag = addr_i[$bits(addr_t)-1:$bits(set_idx_t)];

    // flush blocks the request in the same cycle
    assign accept = req_i && !flush_i;

    for (genvar s = 0; s < `TD_SETS; s++) begin : g_set
        // only the addressed set sees the strobe
        assign sets[s].req = accept && (set_idx == set_idx_t'(s));

        // tag and flush go to every set
        assign sets[s].tag   = tag;
        assign sets[s].flush = flush_i;
    end

endmodule

// File: verilog/tag_set.sv
// ****************************************
// tag set
// tags, valid bits, hit compare, allocation
// ****************************************

`timescale 1ns/1ps

`include "tag_dir_settings.svh"

module tag_set (
    input logic clk_i,
    input logic rst_ni,
    set_if.set  bus
);
    import tag_dir_pkg::*;

    // stored tags, meaningful only where valid
    tag_t     tags_q [`TD_WAYS];
    way_vec_t valid_q;

    way_vec_t hit_vec;
    way_vec_t victim_vec;
    way_vec_t used_vec;
    logic     hit;
    logic     free_any;
    logic     alloc;
    way_idx_t hit_way;
    way_idx_t free_way;
    way_idx_t plru_way;
    way_idx_t alloc_way;

    // compare against every valid way
    always_comb begin : hit_compare
        for (int w = 0; w < `TD_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tags_q[w] == bus.tag);
        end
    end

    assign hit = |hit_vec;

    // descending scan, so the lowest matching way wins
    always_comb begin : way_select
        hit_way  = '0;
        free_way = '0;
        plru_way = '0;
        free_any = 1'b0;
        for (int w = `TD_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = way_idx_t'(w);
            end
            if (!valid_q[w]) begin
                free_way = way_idx_t'(w);
                free_any = 1'b1;
            end
            if (victim_vec[w]) begin
                plru_way = way_idx_t'(w);
            end
        end
    end

    // an empty way beats the tree's victim
    assign alloc_way = free_any ? free_way : plru_way;

    // miss on a request writes the new tag
    assign alloc = bus.req && !hit;

    // results back to the merger
    assign bus.hit         = hit;
    assign bus.way         = hit ? hit_way : alloc_way;
    assign bus.evict_valid = !hit && valid_q[alloc_way];
    assign bus.evict_tag   = tags_q[alloc_way];

    // hit or allocated way becomes most recently used
    assign used_vec = bus.req ? (way_vec_t'(1) << bus.way) : '0;

    plru_tree #(
        .ENTRIES (`TD_WAYS)
    ) i_plru (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .clear  (bus.flush),
        .used   (used_vec),
        .plru   (victim_vec)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (bus.flush) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[alloc_way] <= 1'b1;
        end
    end

    // tag storage
    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tags_q[alloc_way] <= bus.tag;
        end
    end

endmodule

// File: verilog/resp_merge.sv
// ****************************************
// response merger
// registers the addressed set's result
// ****************************************

`timescale 1ns/1ps

`include "tag_dir_settings.svh"

module resp_merge (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_i,
    input  tag_dir_pkg::addr_t    addr_i,
    input  logic                  flush_i,
    set_if.merge                  sets [`TD_SETS],
    output logic                  resp_valid_o,
    output logic                  hit_o,
    output tag_dir_pkg::way_idx_t way_o,
    output logic                  evict_valid_o,
    output tag_dir_pkg::tag_t     evict_tag_o
);
    import tag_dir_pkg::*;

    // per-set results gathered into plain arrays
    logic [`TD_SETS-1:0] hit_s;
    logic [`TD_SETS-1:0] evict_valid_s;
    way_idx_t            way_s [`TD_SETS];
    tag_t                evict_tag_s [`TD_SETS];

    set_idx_t set_idx;
    logic     accept;

    for (genvar s = 0; s < `TD_SETS; s++) begin : g_set
        assign hit_s[s]         = sets[s].hit;
        assign evict_valid_s[s] = sets[s].evict_valid;
        assign way_s[s]         = sets[s].way;
        assign evict_tag_s[s]   = sets[s].evict_tag;
    end

    // same split as the decoder
    assign set_idx = addr_i[$bits(set_idx_t)-1:0];
    assign accept  = req_i && !flush_i;

    // one register stage, results held between responses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_o  <= 1'b0;
            hit_o         <= 1'b0;
            way_o         <= '0;
            evict_valid_o <= 1'b0;
            evict_tag_o   <= '0;
        end else begin
            resp_valid_o <= accept;
            if (accept) begin
                hit_o         <= hit_s[set_idx];
                way_o         <= way_s[set_idx];
                evict_valid_o <= evict_valid_s[set_idx];
                evict_tag_o   <= evict_tag_s[set_idx];
            end
        end
    end

endmodule

// File: verilog/tag_dir_top.sv
// ****************************************
// tag directory top level
// decoder, set array and response merger
// ****************************************

`timescale 1ns/1ps

`include "tag_dir_settings.svh"

module tag_dir_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_i,
    input  tag_dir_pkg::addr_t    addr_i,
    input  logic                  flush_i,
    output logic                  resp_valid_o,
    output logic                  hit_o,
    output tag_dir_pkg::way_idx_t way_o,
    output logic                  evict_valid_o,
    output tag_dir_pkg::tag_t     evict_tag_o
);

    // one bus per set
    set_if sets [`TD_SETS] ();

    // address split and request strobes
    req_decode i_decode (
        .req_i   (req_i),
        .addr_i  (addr_i),
        .flush_i (flush_i),
        .sets    (sets)
    );

    // identical sets, each with its own tree
    for (genvar s = 0; s < `TD_SETS; s++) begin : g_set
        tag_set i_set (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .bus    (sets[s])
        );
    end

    // select and register the addressed result
    resp_merge i_merge (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .flush_i       (flush_i),
        .sets          (sets),
        .resp_valid_o  (resp_valid_o),
        .hit_o         (hit_o),
        .way_o         (way_o),
        .evict_valid_o (evict_valid_o),
        .evict_tag_o   (evict_tag_o)
    );

endmodule

// File: tests/tag_dir_chk.sv
// ****************************************
// tag directory checker
// response timing and consistency assertions
// ****************************************

`timescale 1ns/1ps

module tag_dir_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic req,
    input logic flush,
    input logic resp_valid,
    input logic hit,
    input logic evict_valid
);

    // request taken by the directory this cycle
    logic accept;

    assign accept = req && !flush;

    // every accepted request answers one cycle later
    a_resp_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept |=> resp_valid)
        else $error("no response one cycle after an accepted request");

    // and nothing else produces a response, a flush cycle included
    a_resp_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !accept |=> !resp_valid)
        else $error("response without an accepted request");

    a_hit_evict: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(hit && evict_valid))
        else $error("hit and eviction reported together");

    // no stored tag survives a flush
    a_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept && $past(flush) |=> !hit && !evict_valid)
        else $error("stored tag answered right after a flush");

endmodule

// File: tests/tag_dir_tb.sv
// ****************************************
// tag directory testbench
// directed and seeded random traffic against a set model
// ****************************************

`timescale 1ns/1ps

`include "tag_dir_settings.svh"

module tag_dir_tb;
    import tag_dir_pkg::*;

    localparam int Sets = `TD_SETS;
    localparam int Ways = `TD_WAYS;
    localparam int RandReqs = 200;
    localparam int LongReqs = 1000;
    // fill, hit, replacement, isolation, flush, long run
    localparam int NumReqs = 4 + 4 + 8 + RandReqs + 9 + LongReqs;
    localparam int TimeoutNs = (NumReqs + 5 + 20) * 20;

    logic clk_i;
    logic rst_ni;
    logic req;
    addr_t addr;
    logic flush;
    logic resp_valid;
    logic hit;
    way_idx_t way;
    logic evict_valid;
    tag_t evict_tag;

    // model state, per set
    tag_t m_tag [Sets][Ways];
    logic [Ways-1:0] m_valid [Sets] = '{default: '0};
    logic [Ways-2:0] m_tree [Sets] = '{default: '0};

    // prediction for the request seen last cycle
    logic exp_valid = 1'b0;
    logic exp_hit;
    int exp_way;
    logic exp_evict_valid;
    tag_t exp_evict_tag;
    string exp_name;

    string test_name = "reset";
    // test that drove the inputs now on the bus
    string req_name = "reset";
    int checks = 0;
    int errors = 0;
    int unsigned seed;

    tag_dir_top i_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (req),
        .addr_i        (addr),
        .flush_i       (flush),
        .resp_valid_o  (resp_valid),
        .hit_o         (hit),
        .way_o         (way),
        .evict_valid_o (evict_valid),
        .evict_tag_o   (evict_tag)
    );

    bind tag_dir_top tag_dir_chk i_chk (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req         (req_i),
        .flush       (flush_i),
        .resp_valid  (resp_valid_o),
        .hit         (hit_o),
        .evict_valid (evict_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // walk from the root, 0 goes to the lower half
    function automatic int victim_of(logic [Ways-2:0] tree);
        int node;
        int lo;
        int size;
        node = 0;
        lo = 0;
        size = Ways;
        while (size > 1) begin
            size = size / 2;
            if (tree[node]) begin
                lo += size;
                node = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        return lo;
    endfunction

    // every node on the way's path points away from it
    function automatic logic [Ways-2:0] mark_used(logic [Ways-2:0] tree, int w);
        int node;
        int lo;
        int size;
        node = 0;
        lo = 0;
        size = Ways;
        while (size > 1) begin
            size = size / 2;
            if (w >= lo + size) begin
                tree[node] = 1'b0;
                lo += size;
                node = 2 * node + 2;
            end else begin
                tree[node] = 1'b1;
                node = 2 * node + 1;
            end
        end
        return tree;
    endfunction

    // predict the response and advance the model by one cycle
    task automatic model_step(input logic r, input addr_t a, input logic f);
        int s;
        int w;
        tag_t t;
        s = int'(a[$bits(set_idx_t)-1:0]);
        t = a[$bits(addr_t)-1:$bits(set_idx_t)];
        exp_valid = r && !f;
        exp_name = req_name;
        if (f) begin
            m_valid = '{default: '0};
            m_tree = '{default: '0};
        end else if (r) begin
            exp_hit = 1'b0;
            w = -1;
            for (int i = Ways - 1; i >= 0; i--) begin
                if (m_valid[s][i] && m_tag[s][i] == t) begin
                    exp_hit = 1'b1;
                    w = i;
                end
            end
            if (!exp_hit) begin
                // lowest empty way first, tree victim otherwise
                for (int i = Ways - 1; i >= 0; i--) begin
                    if (!m_valid[s][i]) begin
                        w = i;
                    end
                end
                if (w < 0) begin
                    w = victim_of(m_tree[s]);
                end
                exp_evict_valid = m_valid[s][w];
                exp_evict_tag = m_tag[s][w];
                m_tag[s][w] = t;
                m_valid[s][w] = 1'b1;
            end else begin
                exp_evict_valid = 1'b0;
            end
            exp_way = w;
            m_tree[s] = mark_used(m_tree[s], w);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            compare({exp_name, " resp_valid"}, 32'(exp_valid), 32'(resp_valid));
            if (exp_valid) begin
                compare({exp_name, " hit"}, 32'(exp_hit), 32'(hit));
                compare({exp_name, " way"}, 32'(exp_way), 32'(way));
                compare({exp_name, " evict_valid"}, 32'(exp_evict_valid),
                        32'(evict_valid));
                if (exp_evict_valid) begin
                    compare({exp_name, " evict_tag"}, 32'(exp_evict_tag), 32'(evict_tag));
                end
            end
            model_step(req, addr, flush);
        end
    end

    task automatic drive(input logic r, input tag_t t, input set_idx_t s, input logic f);
        @(posedge clk_i);
        req <= r;
        addr <= {t, s};
        flush <= f;
        req_name <= test_name;
    endtask

    task automatic drive_random(input int count, input int req_pct, input int flush_odds);
        for (int i = 0; i < count; i++) begin
            // eight tags against four ways, so hits and evictions mix
            drive($urandom_range(99, 0) < req_pct, tag_t'($urandom_range(7, 0)),
                  set_idx_t'($urandom_range(Sets - 1, 0)),
                  flush_odds > 0 && $urandom_range(flush_odds - 1, 0) == 0);
        end
    endtask

    initial begin
        #(TimeoutNs);
        $display("timeout: the run did not finish in %0d ns", TimeoutNs);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed = $urandom(32'hadcc_d68d);
        rst_ni = 1'b0;
        req = 1'b0;
        addr = '0;
        flush = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_name = "fill";
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, tag_t'(8'h10 + i), set_idx_t'(1), 1'b0);
        end
        test_name = "hit";
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, tag_t'(8'h10 + i), set_idx_t'(1), 1'b0);
        end
        // full set, every miss evicts
        test_name = "plru";
        for (int i = 0; i < 8; i++) begin
            drive(1'b1, tag_t'(8'h20 + i), set_idx_t'(1), 1'b0);
        end
        test_name = "isolation";
        drive_random(RandReqs, 100, 0);
        // store the tags that the flush must wipe
        test_name = "flush";
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, tag_t'(8'h24 + i), set_idx_t'(1), 1'b0);
        end
        // request in the flush cycle is dropped
        drive(1'b1, tag_t'(8'h27), set_idx_t'(1), 1'b1);
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, tag_t'(8'h24 + i), set_idx_t'(1), 1'b0);
        end
        test_name = "long";
        drive_random(LongReqs, 75, 64);

        drive(1'b0, '0, '0, 1'b0);
        repeat (2) @(posedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+verilog
verilog/tag_dir_pkg.sv
verilog/set_if.sv
verilog/plru_tree.sv
verilog/req_decode.sv
verilog/tag_set.sv
verilog/resp_merge.sv
verilog/tag_dir_top.sv
tests/tag_dir_chk.sv
tests/tag_dir_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tag directory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sim.f --top-module tag_dir_tb -o tag_dir_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tag_dir_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
